/* trace_pkg.sv */
// widths, buffer depth, major opcode and opcode class enums, decode/issue/trace record structs
package trace_pkg;

  //////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int cycle_w    = 32;
  localparam int fifo_depth = 4;
  localparam int lost_w     = 8;

  // buffer index and fill count widths
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // RV32I major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_fence  = 7'b0001111,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } major_opc_e;

  typedef enum logic [3:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_branch,
    op_load,
    op_store,
    op_alu_imm,
    op_alu_reg,
    op_fence,
    op_system,
    op_invalid
  } op_class_e;

  //////////////////////////////////////////////////
  // records
  //////////////////////////////////////////////////

  typedef struct packed {
    op_class_e op_class;
    logic      rd_used;
    logic      rs1_used;
    logic      rs2_used;
  } decode_t;

  // what the core presents at the issue edge
  typedef struct packed {
    logic [xlen-1:0]    pc;
    logic [xlen-1:0]    instr;
    logic [xlen-1:0]    rs1_value;
    logic [xlen-1:0]    rs2_value;
    logic [cycle_w-1:0] cycle;
  } issue_t;

  typedef struct packed {
    logic [cycle_w-1:0]    cycle;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       instr;
    op_class_e             op_class;
    logic                  rd_valid;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rd_value;
    logic                  mem_valid;
    logic                  mem_we;
    logic [xlen-1:0]       mem_addr;
    logic [xlen-1:0]       rs1_value;
    logic [xlen-1:0]       rs2_value;
  } trace_rec_t;

endpackage

/* instr_classifier.sv */
// RV32I instruction word to opcode class and register usage decode
module instr_classifier (
  input  logic [trace_pkg::xlen-1:0] instr,
  output trace_pkg::decode_t         decode
);
  import trace_pkg::*;

  major_opc_e  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        alu_imm_ok;
  logic        alu_reg_ok;

  function automatic decode_t mk(input op_class_e cls, input logic rd, input logic rs1,
                                 input logic rs2);
    decode_t d;
    d.op_class = cls;
    d.rd_used  = rd;
    d.rs1_used = rs1;
    d.rs2_used = rs2;
    return d;
  endfunction

  assign opcode = major_opc_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // shifts carry funct7, the rest of OP-IMM is a plain immediate
  always_comb begin
    case (funct3)
      3'b001:  alu_imm_ok = (funct7 == 7'b0000000);
      3'b101:  alu_imm_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
      default: alu_imm_ok = 1'b1;
    endcase
  end

  // only sub and sra use the alternate funct7
  assign alu_reg_ok = (funct7 == 7'b0000000) ||
                      ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));

  always_comb begin
    decode = mk(op_invalid, 1'b0, 1'b0, 1'b0);
    case (opcode)
      opc_lui:   decode = mk(op_lui, 1'b1, 1'b0, 1'b0);
      opc_auipc: decode = mk(op_auipc, 1'b1, 1'b0, 1'b0);
      opc_jal:   decode = mk(op_jal, 1'b1, 1'b0, 1'b0);
      opc_jalr:
        if (funct3 == 3'b000) decode = mk(op_jalr, 1'b1, 1'b1, 1'b0);
      opc_branch:
        if (funct3[2:1] != 2'b01) decode = mk(op_branch, 1'b0, 1'b1, 1'b1);
      opc_load:
        if ((funct3 != 3'b011) && (funct3[2:1] != 2'b11))
          decode = mk(op_load, 1'b1, 1'b1, 1'b0);
      opc_store:
        if (funct3[2] == 1'b0 && funct3 != 3'b011)
          decode = mk(op_store, 1'b0, 1'b1, 1'b1);
      opc_op_imm:
        if (alu_imm_ok) decode = mk(op_alu_imm, 1'b1, 1'b1, 1'b0);
      opc_op:
        if (alu_reg_ok) decode = mk(op_alu_reg, 1'b1, 1'b1, 1'b1);
      opc_fence:
        if (funct3[2:1] == 2'b00) decode = mk(op_fence, 1'b0, 1'b0, 1'b0);
      opc_system: begin
        // ecall, ebreak, mret, wfi use no registers
        if (funct3 == 3'b000 && instr[19:7] == '0)
          decode = mk(op_system, 1'b0, 1'b0, 1'b0);
        // csr ops, the immediate forms have no rs1
        else if (funct3[1:0] != 2'b00)
          decode = mk(op_system, 1'b1, !funct3[2], 1'b0);
      end
      default: decode = mk(op_invalid, 1'b0, 1'b0, 1'b0);
    endcase
  end

  // a fully driven word always lands in some class
  a_known_class: assert final ($isunknown(instr) || !$isunknown(decode))
    else $error("classifier produced unknown class for %h", instr);

endmodule

/* stage_tracker.sv */
// cycle counter and virtual EX/WB slots building one trace record per retired instruction
module stage_tracker (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // issue
  input  logic [trace_pkg::xlen-1:0]           pc,
  input  logic [trace_pkg::xlen-1:0]           instr,
  input  logic                                 id_valid,
  input  logic                                 is_decoding,
  input  logic [trace_pkg::xlen-1:0]           rs1_value,
  input  logic [trace_pkg::xlen-1:0]           rs2_value,
  // EX stage
  input  logic                                 ex_valid,
  input  logic                                 ex_reg_we,
  input  logic [trace_pkg::reg_addr_w-1:0]     ex_reg_addr,
  input  logic [trace_pkg::xlen-1:0]           ex_reg_wdata,
  input  logic                                 ex_data_req,
  input  logic                                 ex_data_gnt,
  input  logic                                 ex_data_we,
  input  logic [trace_pkg::xlen-1:0]           ex_data_addr,
  // WB stage
  input  logic                                 wb_valid,
  input  logic                                 wb_reg_we,
  input  logic [trace_pkg::reg_addr_w-1:0]     wb_reg_addr,
  input  logic [trace_pkg::xlen-1:0]           wb_reg_wdata,
  // from classifier
  input  trace_pkg::decode_t                   decode,
  // to buffer
  output logic                                 push,
  output trace_pkg::trace_rec_t                rec
);
  import trace_pkg::*;

  logic [cycle_w-1:0] cycle_cnt;
  logic               issue_fire;
  logic               ex_occ;
  logic               wb_occ;
  logic               ex_move;
  logic               wb_retire;
  issue_t             issue;
  trace_rec_t         issue_rec;
  trace_rec_t         ex_rec;
  trace_rec_t         ex_upd;
  trace_rec_t         wb_rec;

  assign issue_fire = id_valid && is_decoding;
  assign ex_move    = ex_occ && ex_valid;
  assign wb_retire  = wb_occ && wb_valid;

  assign issue = '{pc: pc, instr: instr, rs1_value: rs1_value, rs2_value: rs2_value,
                   cycle: cycle_cnt};

  //////////////////////////////////////////////////
  // record at issue
  //////////////////////////////////////////////////

  always_comb begin
    issue_rec           = '0;
    issue_rec.cycle     = issue.cycle;
    issue_rec.pc        = issue.pc;
    issue_rec.instr     = issue.instr;
    issue_rec.op_class  = decode.op_class;
    issue_rec.rd_valid  = decode.rd_used;
    issue_rec.rd        = decode.rd_used ? issue.instr[11:7] : '0;
    // unused sources read as zero
    issue_rec.rs1_value = decode.rs1_used ? issue.rs1_value : '0;
    issue_rec.rs2_value = decode.rs2_used ? issue.rs2_value : '0;
  end

  // EX slot with this edge's write and memory updates applied
  always_comb begin
    ex_upd = ex_rec;
    if (ex_reg_we && ex_rec.rd_valid && (ex_reg_addr == ex_rec.rd))
      ex_upd.rd_value = ex_reg_wdata;
    // only the first granted access counts
    if (ex_data_req && ex_data_gnt && !ex_rec.mem_valid) begin
      ex_upd.mem_valid = 1'b1;
      ex_upd.mem_we    = ex_data_we;
      ex_upd.mem_addr  = ex_data_addr;
    end
  end

  // late writeback value wins on the retire edge
  always_comb begin
    rec = wb_rec;
    if (wb_reg_we && wb_rec.rd_valid && (wb_reg_addr == wb_rec.rd))
      rec.rd_value = wb_reg_wdata;
  end

  assign push = wb_retire;

  //////////////////////////////////////////////////
  // slot state
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
      ex_occ    <= 1'b0;
      wb_occ    <= 1'b0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
      if (issue_fire)
        ex_occ <= 1'b1;
      else if (ex_move)
        ex_occ <= 1'b0;
      if (ex_move)
        wb_occ <= 1'b1;
      else if (wb_retire)
        wb_occ <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_fire)
      ex_rec <= issue_rec;
    else if (ex_occ)
      ex_rec <= ex_upd;
    if (ex_move)
      wb_rec <= ex_upd;
  end

  // core must not issue over an EX entry that is still waiting
  a_issue_free: assert property (@(posedge clk) disable iff (!rst_n)
    issue_fire |-> (!ex_occ || ex_valid));

  // on a handoff, WB retires exactly when it holds something
  a_wb_handoff: assert property (@(posedge clk) disable iff (!rst_n)
    ex_move |-> (wb_valid == wb_occ));

endmodule

/* trace_fifo.sv */
// circular trace record buffer with valid/ready output and saturating lost-record counter
module trace_fifo (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         push,
  input  trace_pkg::trace_rec_t        rec,
  output logic                         trace_valid,
  output trace_pkg::trace_rec_t        trace_rec,
  input  logic                         trace_ready,
  output logic [trace_pkg::lost_w-1:0] lost_count
);
  import trace_pkg::*;

  trace_rec_t            mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_cnt_w-1:0] count;
  logic                  full;
  logic                  pop;
  logic                  do_write;
  logic                  drop;

  assign trace_valid = (count != '0);
  assign trace_rec   = mem[rd_ptr];
  assign full        = (count == fifo_cnt_w'(fifo_depth));
  assign pop         = trace_valid && trace_ready;
  // a pop on the same edge makes room
  assign do_write    = push && (!full || pop);
  assign drop        = push && full && !pop;

  always_ff @(posedge clk) begin
    if (do_write)
      mem[wr_ptr] <= rec;
  end

  //////////////////////////////////////////////////
  // pointers, fill level, drop counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      lost_count <= '0;
    end else begin
      // depth is a power of two, pointers wrap on their own
      if (do_write)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_write, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (drop && (lost_count != '1))
        lost_count <= lost_count + 1'b1;
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= fifo_cnt_w'(fifo_depth));

endmodule

/* instr_tracer.sv */
// top level of the retirement tracer: classifier, stage tracker, output buffer
module instr_tracer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [trace_pkg::xlen-1:0]       pc,
  input  logic [trace_pkg::xlen-1:0]       instr,
  input  logic                             id_valid,
  input  logic                             is_decoding,
  input  logic [trace_pkg::xlen-1:0]       rs1_value,
  input  logic [trace_pkg::xlen-1:0]       rs2_value,
  input  logic                             ex_valid,
  input  logic                             ex_reg_we,
  input  logic [trace_pkg::reg_addr_w-1:0] ex_reg_addr,
  input  logic [trace_pkg::xlen-1:0]       ex_reg_wdata,
  input  logic                             ex_data_req,
  input  logic                             ex_data_gnt,
  input  logic                             ex_data_we,
  input  logic [trace_pkg::xlen-1:0]       ex_data_addr,
  input  logic                             wb_valid,
  input  logic                             wb_reg_we,
  input  logic [trace_pkg::reg_addr_w-1:0] wb_reg_addr,
  input  logic [trace_pkg::xlen-1:0]       wb_reg_wdata,
  output logic                             trace_valid,
  output trace_pkg::trace_rec_t            trace_rec,
  input  logic                             trace_ready,
  output logic [trace_pkg::lost_w-1:0]     lost_count
);
  import trace_pkg::*;

  decode_t    decode;
  logic       push;
  trace_rec_t rec;

  instr_classifier u_classifier (
    .instr  (instr),
    .decode (decode)
  );

  stage_tracker u_tracker (
    .clk, .rst_n, .pc, .instr, .id_valid, .is_decoding, .rs1_value, .rs2_value,
    .ex_valid, .ex_reg_we, .ex_reg_addr, .ex_reg_wdata,
    .ex_data_req, .ex_data_gnt, .ex_data_we, .ex_data_addr,
    .wb_valid, .wb_reg_we, .wb_reg_addr, .wb_reg_wdata,
    .decode (decode),
    .push   (push),
    .rec    (rec)
  );

  trace_fifo u_fifo (
    .clk, .rst_n,
    .push        (push),
    .rec         (rec),
    .trace_valid (trace_valid),
    .trace_rec   (trace_rec),
    .trace_ready (trace_ready),
    .lost_count  (lost_count)
  );

endmodule

/* tb_instr_tracer.sv */
// testbench for the retirement tracer: core model, expected record queue, output checks
module tb_instr_tracer;
  import trace_pkg::*;

  logic                  clk;
  logic                  rst_n;
  logic [xlen-1:0]       pc, instr, rs1_value, rs2_value;
  logic [xlen-1:0]       ex_reg_wdata, ex_data_addr, wb_reg_wdata;
  logic [reg_addr_w-1:0] ex_reg_addr, wb_reg_addr;
  logic                  id_valid, is_decoding, ex_valid, ex_reg_we;
  logic                  ex_data_req, ex_data_gnt, ex_data_we, wb_valid, wb_reg_we;
  logic                  trace_valid, trace_ready;
  logic [lost_w-1:0]     lost_count;
  trace_rec_t            trace_rec;

  // expected records in issue order
  trace_rec_t exp_mem [64];
  trace_rec_t exp_head;
  int         push_idx = 0;
  int         pop_idx = 0;
  int         errors = 0;
  int         test_errors = 0;
  int         tests = 0;
  int         tb_cycle;
  integer     seed;
  string      test_name;

  instr_tracer uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // cycle stamp reference, 0 in the first cycle after reset
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      tb_cycle <= 0;
    else
      tb_cycle <= tb_cycle + 1;
  end

  assign exp_head = exp_mem[pop_idx];

  always @(posedge clk) begin
    if (rst_n && trace_valid && trace_ready)
      pop_idx <= pop_idx + 1;
  end

  //////////////////////////////////////////////////
  // output stream checks
  //////////////////////////////////////////////////

  a_expected: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_valid && trace_ready) |-> (pop_idx < push_idx))
    else begin
      errors++;
      $display("%s: a trace record came out when none was expected", test_name);
    end

  a_record: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_valid && trace_ready && pop_idx < push_idx) |-> (trace_rec == exp_head))
    else begin
      errors++;
      $display("error %s: expected %h, actual %h", test_name, $sampled(exp_head),
               $sampled(trace_rec));
    end

  // {rd, rs1, rs2} usage per class
  function automatic logic [2:0] reg_use(input op_class_e c);
    case (c)
      op_lui, op_auipc, op_jal:     return 3'b100;
      op_jalr, op_load, op_alu_imm: return 3'b110;
      op_branch, op_store:          return 3'b011;
      op_alu_reg:                   return 3'b111;
      default:                      return 3'b000;
    endcase
  endfunction

  // one instruction through issue, EX and WB with random stalls
  task automatic run_instr(input logic [xlen-1:0] ipc, input logic [xlen-1:0] iw,
                           input op_class_e c, input logic [xlen-1:0] v1,
                           input logic [xlen-1:0] v2, input logic [xlen-1:0] wdata,
                           input logic mem, input logic mw, input logic [xlen-1:0] maddr);
    trace_rec_t e;
    logic [2:0] regs;
    regs = reg_use(c);
    repeat ($unsigned($random(seed)) % 3 + 1) @(negedge clk);
    pc = ipc;
    instr = iw;
    rs1_value = v1;
    rs2_value = v2;
    id_valid = 1'b1;
    is_decoding = 1'b1;
    e = '0;
    e.cycle = tb_cycle;
    e.pc = ipc;
    e.instr = iw;
    e.op_class = c;
    e.rd_valid = regs[2];
    e.rd = regs[2] ? iw[11:7] : '0;
    e.rd_value = regs[2] ? wdata : '0;
    e.mem_valid = mem;
    e.mem_we = mem && mw;
    e.mem_addr = mem ? maddr : '0;
    e.rs1_value = regs[1] ? v1 : '0;
    e.rs2_value = regs[0] ? v2 : '0;
    @(negedge clk);
    id_valid = 1'b0;
    is_decoding = 1'b0;
    // ungranted request first, then the access that counts
    ex_data_req = mem;
    @(negedge clk);
    ex_data_gnt = mem;
    ex_data_we = mw;
    ex_data_addr = maddr;
    // early EX result, WB overrides it
    ex_reg_we = regs[2];
    ex_reg_addr = iw[11:7];
    ex_reg_wdata = ~wdata;
    @(negedge clk);
    ex_reg_we = 1'b0;
    ex_data_addr = ~maddr;
    repeat ($unsigned($random(seed)) % 3) @(negedge clk);
    ex_valid = 1'b1;
    ex_data_req = 1'b0;
    ex_data_gnt = 1'b0;
    @(negedge clk);
    ex_valid = 1'b0;
    repeat ($unsigned($random(seed)) % 3) @(negedge clk);
    wb_valid = 1'b1;
    wb_reg_we = regs[2];
    wb_reg_addr = iw[11:7];
    wb_reg_wdata = wdata;
    // a push into a full buffer is lost
    if (push_idx - pop_idx < fifo_depth) begin
      exp_mem[push_idx] = e;
      push_idx++;
    end
    @(negedge clk);
    wb_valid = 1'b0;
    wb_reg_we = 1'b0;
  endtask

  // let the buffer empty, then report the test
  task automatic finish_test();
    int n;
    n = 0;
    while (pop_idx != push_idx && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (pop_idx != push_idx) begin
      errors++;
      $display("%s: timed out with %0d trace records still missing", test_name,
               push_idx - pop_idx);
    end
    $display("%s: done, %0d errors", test_name, errors - test_errors);
    test_errors = errors;
    tests++;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [xlen-1:0] r;
    logic [xlen-1:0] pc_i;
    seed = 48;
    rst_n = 1'b0;
    trace_ready = 1'b1;
    {id_valid, is_decoding, ex_valid, ex_reg_we, ex_data_req, ex_data_gnt} = '0;
    {ex_data_we, wb_valid, wb_reg_we, ex_reg_addr, wb_reg_addr} = '0;
    {pc, instr, rs1_value, rs2_value, ex_reg_wdata, ex_data_addr, wb_reg_wdata} = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    test_name = "after_reset";
    @(negedge clk);
    a_reset: assert (!trace_valid && lost_count == '0)
      else begin
        errors++;
        $display("error %s: expected valid 0 lost 0, actual valid %b lost %0d", test_name,
                 trace_valid, lost_count);
      end
    finish_test();

    test_name = "alu";
    run_instr(32'h100, 32'h00C08293, op_alu_imm, 32'h11, 32'h22, 32'h1d, 1'b0, 1'b0, '0);
    run_instr(32'h104, 32'h00310333, op_alu_reg, 32'h5, 32'h7, 32'hc, 1'b0, 1'b0, '0);
    finish_test();

    test_name = "load_store";
    run_instr(32'h108, 32'h00822383, op_load, 32'h2000, 32'h33, 32'hcafe, 1'b1, 1'b0, 32'h2008);
    run_instr(32'h10c, 32'h0084A223, op_store, 32'h3000, 32'hbeef, '0, 1'b1, 1'b1, 32'h3004);
    finish_test();

    test_name = "branch_invalid";
    run_instr(32'h110, 32'h00208863, op_branch, 32'h9, 32'h9, '0, 1'b0, 1'b0, '0);
    run_instr(32'h114, 32'hffffffff, op_invalid, 32'h1, 32'h2, '0, 1'b0, 1'b0, '0);
    run_instr(32'h118, 32'h00000000, op_invalid, 32'h3, 32'h4, '0, 1'b0, 1'b0, '0);
    finish_test();

    test_name = "order_stamps";
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      pc_i = 32'h200 + 4 * i;
      case (i % 4)
        0: run_instr(pc_i, 32'h00310333, op_alu_reg, r, ~r, r + 1, 1'b0, 1'b0, '0);
        1: run_instr(pc_i, 32'h00822383, op_load, r, '0, ~r, 1'b1, 1'b0, r & ~32'h3);
        2: run_instr(pc_i, 32'h0084A223, op_store, r, r ^ 32'h77, '0, 1'b1, 1'b1, r + 4);
        default: run_instr(pc_i, 32'h00208863, op_branch, r, r, '0, 1'b0, 1'b0, '0);
      endcase
    end
    finish_test();

    test_name = "backpressure";
    trace_ready = 1'b0;
    for (int i = 0; i < 6; i++)
      run_instr(32'h300 + 4 * i, 32'h00C08293, op_alu_imm, i, '0, 32'h40 + i, 1'b0, 1'b0, '0);
    @(negedge clk);
    a_lost: assert (lost_count == lost_w'(2))
      else begin
        errors++;
        $display("error %s: expected lost_count 2, actual %0d", test_name, lost_count);
      end
    trace_ready = 1'b1;
    finish_test();

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* project.f */
trace_pkg.sv
instr_classifier.sv
stage_tracker.sv
trace_fifo.sv
instr_tracer.sv
tb_instr_tracer.sv
